// File: mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Scratchpad geometry
`define MEM_ADDR_WIDTH   8
`define MEM_BYTES        4
`define MEM_DATA_WIDTH   32
`define AXIL_ADDR_WIDTH  12

// Register window, full bus addresses
`define REG_SRC          12'h800
`define REG_DST          12'h804
`define REG_LEN          12'h808
`define REG_CTRL         12'h80C
`define REG_STATUS       12'h810
`define REG_PATTERN      12'h814

`define RESP_OKAY        2'b00
`define RESP_SLVERR      2'b10

`endif

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

  typedef enum logic [1:0] {
    ST_IDLE       = 2'd0,
    ST_WRITE_RESP = 2'd1,
    ST_READ_WAIT  = 2'd2, // Memory read in flight
    ST_READ_RESP  = 2'd3
  } ctrl_state_e;

  typedef enum logic {
    OP_FILL = 1'b0,
    OP_COPY = 1'b1
  } mover_op_e;

  typedef enum logic [1:0] {
    MV_IDLE       = 2'd0,
    MV_FILL       = 2'd1,
    MV_COPY_READ  = 2'd2,
    MV_COPY_WRITE = 2'd3
  } mover_state_e;

endpackage

`default_nettype wire

// File: mem_2rw.sv
`timescale 1ns/10ps
`default_nettype none

module mem_2rw #(
  parameter int BYTES_PER_LINE = 4,
  parameter int ADDR_WIDTH     = 8
) (
  input  wire logic                        clk,

  input  wire logic                        ena,
  input  wire logic [BYTES_PER_LINE-1:0]   wea,
  input  wire logic [ADDR_WIDTH-1:0]       addra,
  input  wire logic [8*BYTES_PER_LINE-1:0] dina,
  output logic      [8*BYTES_PER_LINE-1:0] douta,

  input  wire logic                        enb,
  input  wire logic [BYTES_PER_LINE-1:0]   web,
  input  wire logic [ADDR_WIDTH-1:0]       addrb,
  input  wire logic [8*BYTES_PER_LINE-1:0] dinb,
  output logic      [8*BYTES_PER_LINE-1:0] doutb
);

  localparam int LINE_SIZE = 8 * BYTES_PER_LINE;

  logic [LINE_SIZE-1:0] mem [0:(2**ADDR_WIDTH)-1];
  logic [LINE_SIZE-1:0] mem_out_a;
  logic [LINE_SIZE-1:0] mem_out_b;

  // Port A
  always @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (wea[i])
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
      end
      if (~|wea)
        mem_out_a <= mem[addra]; // Read only when no byte is written
    end
  end

  // Port B
  always @(posedge clk) begin
    if (enb) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (web[i])
          mem[addrb][i*8 +: 8] <= dinb[i*8 +: 8];
      end
      if (~|web)
        mem_out_b <= mem[addrb];
    end
  end

  assign douta = mem_out_a;
  assign doutb = mem_out_b;

endmodule

`default_nettype wire

// File: axil_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module axil_mem_ctrl (
  input  wire logic                         clk,
  input  wire logic                         rst,

  input  wire logic [`AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  wire logic                         awvalid,
  output logic                              awready,
  input  wire logic [`MEM_DATA_WIDTH-1:0]   wdata,
  input  wire logic [`MEM_BYTES-1:0]        wstrb,
  input  wire logic                         wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  wire logic                         bready,
  input  wire logic [`AXIL_ADDR_WIDTH-1:0]  araddr,
  input  wire logic                         arvalid,
  output logic                              arready,
  output logic [`MEM_DATA_WIDTH-1:0]        rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  wire logic                         rready,

  output logic                              ram_a_en,
  output logic [`MEM_BYTES-1:0]             ram_a_we,
  output logic [`MEM_ADDR_WIDTH-1:0]        ram_a_addr,
  output logic [`MEM_DATA_WIDTH-1:0]        ram_a_wdata,
  input  wire logic [`MEM_DATA_WIDTH-1:0]   ram_a_rdata,

  input  wire logic                         mv_busy,
  input  wire logic                         mv_done_pulse,
  output logic                              mv_start,
  output mem_pkg::mover_op_e                mv_op,
  output logic [`MEM_ADDR_WIDTH-1:0]        mv_src,
  output logic [`MEM_ADDR_WIDTH-1:0]        mv_dst,
  output logic [`MEM_ADDR_WIDTH:0]          mv_len,
  output logic [`MEM_DATA_WIDTH-1:0]        mv_pattern
);

  import mem_pkg::*;

  ctrl_state_e                  state;
  logic                         done_q;    // Sticky done
  logic                         wr_hs;
  logic                         rd_hs;
  logic                         wr_is_mem;
  logic                         rd_is_mem;
  logic                         wr_err;
  logic                         rd_err;
  logic                         wr_reg_miss;
  logic                         rd_reg_miss;
  logic [`AXIL_ADDR_WIDTH-1:0]  wr_reg_addr;
  logic [`AXIL_ADDR_WIDTH-1:0]  rd_reg_addr;
  logic [`MEM_DATA_WIDTH-1:0]   reg_rdata;

  // Read wins over a pending write
  assign rd_hs   = (state == ST_IDLE) & arvalid;
  assign wr_hs   = (state == ST_IDLE) & awvalid & wvalid & ~arvalid;
  assign arready = rd_hs;
  assign awready = wr_hs;
  assign wready  = wr_hs;

  // Bit 11 picks the window, bit 10 marks the unmapped half of memory
  assign wr_is_mem   = ~awaddr[`AXIL_ADDR_WIDTH-1] & ~awaddr[`AXIL_ADDR_WIDTH-2];
  assign rd_is_mem   = ~araddr[`AXIL_ADDR_WIDTH-1] & ~araddr[`AXIL_ADDR_WIDTH-2];
  assign wr_reg_addr = {awaddr[`AXIL_ADDR_WIDTH-1:2], 2'b00};
  assign rd_reg_addr = {araddr[`AXIL_ADDR_WIDTH-1:2], 2'b00};
  assign wr_err      = ~wr_is_mem & (~awaddr[`AXIL_ADDR_WIDTH-1] | wr_reg_miss);
  assign rd_err      = ~rd_is_mem & (~araddr[`AXIL_ADDR_WIDTH-1] | rd_reg_miss);

  always_comb begin
    case (wr_reg_addr)
      `REG_SRC, `REG_DST, `REG_LEN, `REG_CTRL, `REG_PATTERN: wr_reg_miss = 1'b0;
      default: wr_reg_miss = 1'b1; // Status is read-only
    endcase
  end

  always_comb begin
    reg_rdata   = '0;
    rd_reg_miss = 1'b0;
    case (rd_reg_addr)
      `REG_SRC:     reg_rdata[`MEM_ADDR_WIDTH-1:0] = mv_src;
      `REG_DST:     reg_rdata[`MEM_ADDR_WIDTH-1:0] = mv_dst;
      `REG_LEN:     reg_rdata[`MEM_ADDR_WIDTH:0]   = mv_len;
      `REG_CTRL:    reg_rdata[1]                   = mv_op;
      `REG_STATUS:  reg_rdata[1:0]                 = {done_q, mv_busy};
      `REG_PATTERN: reg_rdata                      = mv_pattern;
      default:      rd_reg_miss                    = 1'b1;
    endcase
  end

  // Port A serves both the read and the write handshake
  assign ram_a_en    = (rd_hs & rd_is_mem) | (wr_hs & wr_is_mem);
  assign ram_a_we    = {`MEM_BYTES{wr_hs & wr_is_mem}} & wstrb;
  assign ram_a_addr  = rd_hs ? araddr[`MEM_ADDR_WIDTH+1:2] : awaddr[`MEM_ADDR_WIDTH+1:2];
  assign ram_a_wdata = wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      mv_start   <= 1'b0;
      mv_op      <= OP_FILL;
      mv_src     <= '0;
      mv_dst     <= '0;
      mv_len     <= '0;
      mv_pattern <= '0;
      done_q     <= 1'b0;
    end else begin
      mv_start <= 1'b0;
      if (mv_start)
        done_q <= 1'b0;
      else if (mv_done_pulse)
        done_q <= 1'b1;

      case (state)
        ST_IDLE: begin
          if (rd_hs) begin
            if (rd_is_mem) begin
              state <= ST_READ_WAIT;
            end else begin
              state  <= ST_READ_RESP;
              rvalid <= 1'b1;
            end
          end else if (wr_hs) begin
            state  <= ST_WRITE_RESP;
            bvalid <= 1'b1;
            if (!wr_is_mem) begin
              case (wr_reg_addr)
                `REG_SRC:     mv_src     <= wdata[`MEM_ADDR_WIDTH-1:0];
                `REG_DST:     mv_dst     <= wdata[`MEM_ADDR_WIDTH-1:0];
                `REG_LEN:     mv_len     <= wdata[`MEM_ADDR_WIDTH:0];
                `REG_PATTERN: mv_pattern <= wdata;
                `REG_CTRL: begin
                  mv_op    <= mover_op_e'(wdata[1]);
                  mv_start <= wdata[0] & ~mv_busy; // Ignored while a run is active
                end
                default: ;
              endcase
            end
          end
        end
        ST_READ_WAIT: begin
          state  <= ST_READ_RESP;
          rvalid <= 1'b1;
        end
        ST_READ_RESP: begin
          if (rready) begin
            state  <= ST_IDLE;
            rvalid <= 1'b0;
          end
        end
        ST_WRITE_RESP: begin
          if (bready) begin
            state  <= ST_IDLE;
            bvalid <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rresp <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
      rdata <= reg_rdata;
    end else if (wr_hs) begin
      bresp <= wr_err ? `RESP_SLVERR : `RESP_OKAY;
    end else if (state == ST_READ_WAIT) begin
      rdata <= ram_a_rdata;
    end
  end

endmodule

`default_nettype wire

// File: block_mover.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module block_mover (
  input  wire logic                        clk,
  input  wire logic                        rst,

  input  wire logic                        mv_start,
  input  wire mem_pkg::mover_op_e          mv_op,
  input  wire logic [`MEM_ADDR_WIDTH-1:0]  mv_src,
  input  wire logic [`MEM_ADDR_WIDTH-1:0]  mv_dst,
  input  wire logic [`MEM_ADDR_WIDTH:0]    mv_len,
  input  wire logic [`MEM_DATA_WIDTH-1:0]  mv_pattern,
  output logic                             mv_busy,
  output logic                             mv_done_pulse,

  output logic                             ram_b_en,
  output logic [`MEM_BYTES-1:0]            ram_b_we,
  output logic [`MEM_ADDR_WIDTH-1:0]       ram_b_addr,
  output logic [`MEM_DATA_WIDTH-1:0]       ram_b_wdata,
  input  wire logic [`MEM_DATA_WIDTH-1:0]  ram_b_rdata
);

  import mem_pkg::*;

  localparam logic [`MEM_ADDR_WIDTH:0] LEN_ONE = 1;

  mover_state_e                  state;
  logic [`MEM_ADDR_WIDTH:0]      cnt;       // Words still to write
  logic [`MEM_ADDR_WIDTH-1:0]    src_q;
  logic [`MEM_ADDR_WIDTH-1:0]    dst_q;
  logic [`MEM_DATA_WIDTH-1:0]    pattern_q;
  logic                          writing;

  assign mv_busy = (state != MV_IDLE);
  assign writing = (state == MV_FILL) | (state == MV_COPY_WRITE);

  assign ram_b_en    = mv_busy;
  assign ram_b_we    = {`MEM_BYTES{writing}};
  assign ram_b_addr  = (state == MV_COPY_READ) ? src_q : dst_q;
  assign ram_b_wdata = (state == MV_FILL) ? pattern_q : ram_b_rdata; // Copy data one cycle old

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= MV_IDLE;
      cnt           <= '0;
      src_q         <= '0;
      dst_q         <= '0;
      mv_done_pulse <= 1'b0;
    end else begin
      mv_done_pulse <= 1'b0;
      case (state)
        MV_IDLE: begin
          if (mv_start) begin
            src_q <= mv_src;
            dst_q <= mv_dst;
            cnt   <= mv_len;
            if (mv_len == '0)
              mv_done_pulse <= 1'b1; // Nothing to move
            else if (mv_op == OP_COPY)
              state <= MV_COPY_READ;
            else
              state <= MV_FILL;
          end
        end
        MV_FILL: begin
          dst_q <= dst_q + 1'b1;
          cnt   <= cnt - 1'b1;
          if (cnt == LEN_ONE) begin
            state         <= MV_IDLE;
            mv_done_pulse <= 1'b1;
          end
        end
        MV_COPY_READ: begin
          src_q <= src_q + 1'b1;
          state <= MV_COPY_WRITE;
        end
        MV_COPY_WRITE: begin
          dst_q <= dst_q + 1'b1;
          cnt   <= cnt - 1'b1;
          if (cnt == LEN_ONE) begin
            state         <= MV_IDLE;
            mv_done_pulse <= 1'b1;
          end else begin
            state <= MV_COPY_READ;
          end
        end
        default: state <= MV_IDLE;
      endcase
    end
  end

  // Pattern is frozen for the whole run
  always_ff @(posedge clk) begin
    if (mv_start && state == MV_IDLE)
      pattern_q <= mv_pattern;
  end

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module mem_subsys_top (
  input  wire logic                         clk,
  input  wire logic                         rst,

  input  wire logic [`AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  wire logic                         awvalid,
  output logic                              awready,
  input  wire logic [`MEM_DATA_WIDTH-1:0]   wdata,
  input  wire logic [`MEM_BYTES-1:0]        wstrb,
  input  wire logic                         wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  wire logic                         bready,
  input  wire logic [`AXIL_ADDR_WIDTH-1:0]  araddr,
  input  wire logic                         arvalid,
  output logic                              arready,
  output logic [`MEM_DATA_WIDTH-1:0]        rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  wire logic                         rready
);

  import mem_pkg::*;

  logic                        ram_a_en;
  logic [`MEM_BYTES-1:0]       ram_a_we;
  logic [`MEM_ADDR_WIDTH-1:0]  ram_a_addr;
  logic [`MEM_DATA_WIDTH-1:0]  ram_a_wdata;
  logic [`MEM_DATA_WIDTH-1:0]  ram_a_rdata;
  logic                        ram_b_en;
  logic [`MEM_BYTES-1:0]       ram_b_we;
  logic [`MEM_ADDR_WIDTH-1:0]  ram_b_addr;
  logic [`MEM_DATA_WIDTH-1:0]  ram_b_wdata;
  logic [`MEM_DATA_WIDTH-1:0]  ram_b_rdata;
  logic                        mv_start;
  mover_op_e                   mv_op;
  logic [`MEM_ADDR_WIDTH-1:0]  mv_src;
  logic [`MEM_ADDR_WIDTH-1:0]  mv_dst;
  logic [`MEM_ADDR_WIDTH:0]    mv_len;
  logic [`MEM_DATA_WIDTH-1:0]  mv_pattern;
  logic                        mv_busy;
  logic                        mv_done_pulse;

  axil_mem_ctrl u_ctrl (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .ram_a_en, .ram_a_we, .ram_a_addr, .ram_a_wdata, .ram_a_rdata,
    .mv_busy, .mv_done_pulse, .mv_start, .mv_op, .mv_src, .mv_dst, .mv_len, .mv_pattern
  );

  block_mover u_mover (
    .clk, .rst,
    .mv_start, .mv_op, .mv_src, .mv_dst, .mv_len, .mv_pattern, .mv_busy, .mv_done_pulse,
    .ram_b_en, .ram_b_we, .ram_b_addr, .ram_b_wdata, .ram_b_rdata
  );

  // Port A belongs to the bus, port B to the mover
  mem_2rw #(
    .BYTES_PER_LINE (`MEM_BYTES),
    .ADDR_WIDTH     (`MEM_ADDR_WIDTH)
  ) u_ram (
    .clk   (clk),
    .ena   (ram_a_en),
    .wea   (ram_a_we),
    .addra (ram_a_addr),
    .dina  (ram_a_wdata),
    .douta (ram_a_rdata),
    .enb   (ram_b_en),
    .web   (ram_b_we),
    .addrb (ram_b_addr),
    .dinb  (ram_b_wdata),
    .doutb (ram_b_rdata)
  );

endmodule

`default_nettype wire

// File: mem_subsys_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module mem_subsys_properties (
  input wire logic                        clk,
  input wire logic                        rst,
  input wire logic                        bvalid,
  input wire logic                        bready,
  input wire logic [1:0]                  bresp,
  input wire logic                        rvalid,
  input wire logic                        rready,
  input wire logic [`MEM_DATA_WIDTH-1:0]  rdata,
  input wire logic [1:0]                  rresp,
  input wire logic                        ram_b_en,
  input wire logic [`MEM_BYTES-1:0]       ram_b_we,
  input wire logic                        mv_busy,
  input wire logic                        mv_start,
  input wire logic                        mv_done_pulse
);

  int   fail_count = 0;
  logic run_active; // Start seen, done not yet seen

  always_ff @(posedge clk) begin
    if (rst)
      run_active <= 1'b0;
    else if (mv_start)
      run_active <= 1'b1;
    else if (mv_done_pulse)
      run_active <= 1'b0;
  end

  bresp_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("Write response changed or dropped before bready");
      fail_count++;
    end

  rresp_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("Read response changed or dropped before rready");
      fail_count++;
    end

  // Mover owns port B only during a run
  portb_write_busy: assert property (@(posedge clk) disable iff (rst)
    ram_b_en && (ram_b_we != '0) |-> run_active)
    else begin
      $error("Port B written outside a mover run");
      fail_count++;
    end

  busy_in_run: assert property (@(posedge clk) disable iff (rst)
    mv_busy |-> run_active)
    else begin
      $error("Mover busy without a start from the controller");
      fail_count++;
    end

  reset_idle: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
    else begin
      $error("Response valid high right after reset");
      fail_count++;
    end

endmodule

bind mem_subsys_top mem_subsys_properties u_props (
  .clk(clk), .rst(rst),
  .bvalid(bvalid), .bready(bready), .bresp(bresp),
  .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
  .ram_b_en(ram_b_en), .ram_b_we(ram_b_we), .mv_busy(mv_busy),
  .mv_start(mv_start), .mv_done_pulse(mv_done_pulse)
);

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int WORDS      = 2**`MEM_ADDR_WIDTH;
  localparam int MAX_CYCLES = 20000;

  logic                         clk;
  logic                         rst;
  logic [`AXIL_ADDR_WIDTH-1:0]  awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [`MEM_DATA_WIDTH-1:0]   wdata;
  logic [`MEM_BYTES-1:0]        wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [`AXIL_ADDR_WIDTH-1:0]  araddr;
  logic                         arvalid;
  logic                         arready;
  logic [`MEM_DATA_WIDTH-1:0]   rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;

  logic [`MEM_DATA_WIDTH-1:0]   ref_mem [0:WORDS-1]; // Reference memory model
  logic [31:0]                  reg_model [0:5];     // SRC, DST, LEN, CTRL, STATUS, PATTERN
  int                           errors;
  int                           cycles;

  mem_subsys_top dut (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d failed checks, %0d failed assertions", errors,
               dut.u_props.fail_count);
      $display("sim failed");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("ERROR time=%0t %s", $time, what);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i])
        res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold, output logic [1:0] resp);
    int delay;
    delay = int'($urandom_range(3, 0)) + hold;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk); // Handshake taken on the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    repeat (delay) begin
      @(negedge clk);
      expect_true(bvalid, "write response withdrawn before bready");
    end
    bready = 1'b1;
    resp   = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int delay;
    delay = int'($urandom_range(3, 0)) + hold;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    repeat (delay) begin
      @(negedge clk);
      expect_true(rvalid, "read response withdrawn before rready");
    end
    rready = 1'b1;
    data   = rdata;
    resp   = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_checked(input logic [11:0] addr, input logic [31:0] data,
                               input int hold, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, 4'hf, hold, resp);
    compare_value($sformatf("bresp@%h", addr), 32'(resp), 32'(exp_resp));
  endtask

  task automatic read_checked(input logic [11:0] addr, input int hold,
                              input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, hold, data, resp);
    compare_value($sformatf("rresp@%h", addr), 32'(resp), 32'(exp_resp));
    if (exp_resp == `RESP_OKAY)
      compare_value($sformatf("rdata@%h", addr), data, exp_data);
  endtask

  task automatic mem_write(input logic [7:0] idx, input logic [31:0] data, input logic [3:0] strb);
    logic [1:0] resp;
    axil_write({2'b00, idx, 2'b00}, data, strb, 0, resp);
    compare_value("bresp", 32'(resp), 32'(`RESP_OKAY));
    ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
  endtask

  task automatic check_range(input int first, input int count);
    logic [7:0] idx;
    for (int k = 0; k < count; k++) begin
      idx = 8'(first + k);
      read_checked({2'b00, idx, 2'b00}, 0, ref_mem[idx], `RESP_OKAY);
    end
  endtask

  task automatic run_mover(input mover_op_e op, input logic [7:0] src, input logic [7:0] dst,
                           input int len, input logic [31:0] pattern);
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    write_checked(`REG_SRC, 32'(src), 0, `RESP_OKAY);
    write_checked(`REG_DST, 32'(dst), 0, `RESP_OKAY);
    write_checked(`REG_LEN, 32'(len), 0, `RESP_OKAY);
    write_checked(`REG_PATTERN, pattern, 0, `RESP_OKAY);
    write_checked(`REG_CTRL, {30'd0, op, 1'b1}, 0, `RESP_OKAY);
    reg_model[0] = 32'(src);
    reg_model[1] = 32'(dst);
    reg_model[2] = 32'(len);
    reg_model[3] = {30'd0, op, 1'b0};
    reg_model[4] = 32'd2; // Done, not busy
    reg_model[5] = pattern;
    polls = 0;
    do begin
      axil_read(`REG_STATUS, 0, status, resp);
      polls++;
    end while (status[1:0] != 2'b10 && polls < 300);
    expect_true(status[1:0] == 2'b10, "mover never reported done with busy clear");
    for (int i = 0; i < len; i++) begin
      if (op == OP_FILL)
        ref_mem[8'(dst + i)] = pattern;
      else
        ref_mem[8'(dst + i)] = ref_mem[8'(src + i)]; // Forward order sees earlier writes
    end
  endtask

  task automatic check_registers(input int hold);
    read_checked(`REG_SRC, hold, reg_model[0], `RESP_OKAY);
    read_checked(`REG_DST, hold, reg_model[1], `RESP_OKAY);
    read_checked(`REG_LEN, hold, reg_model[2], `RESP_OKAY);
    read_checked(`REG_CTRL, hold, reg_model[3], `RESP_OKAY);
    read_checked(`REG_STATUS, hold, reg_model[4], `RESP_OKAY);
    read_checked(`REG_PATTERN, hold, reg_model[5], `RESP_OKAY);
  endtask

  task automatic word_access();
    logic [7:0] addrs [32];
    logic [7:0] tmp;
    int         j;
    for (int i = 0; i < 32; i++) begin
      addrs[i] = 8'($urandom);
      mem_write(addrs[i], $urandom, 4'hf);
    end
    for (int i = 31; i > 0; i--) begin
      j        = int'($urandom_range(i, 0));
      tmp      = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    for (int i = 0; i < 32; i++)
      check_range(int'(addrs[i]), 1);
  endtask

  task automatic byte_strobes();
    for (int s = 1; s < 15; s++) begin
      mem_write(8'(20 + s), $urandom, 4'(s));
      check_range(20 + s, 1);
    end
  endtask

  task automatic errors_and_backpressure();
    write_checked(12'h500, 32'hdead_beef, 8, `RESP_SLVERR);
    read_checked(12'h500, 9, 32'd0, `RESP_SLVERR);
    write_checked(12'h818, 32'h1234_5678, 10, `RESP_SLVERR);
    read_checked(12'h818, 7, 32'd0, `RESP_SLVERR);
    write_checked(`REG_STATUS, 32'h3, 12, `RESP_SLVERR);
    check_range(8'h40, 1); // 0x500 aliases this word index
    check_registers(11);
  endtask

  initial begin
    void'($urandom(32'hf765f2c6));
    clk     = 1'b0;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    errors  = 0;
    cycles  = 0;
    for (int i = 0; i < 6; i++)
      reg_model[i] = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    check_registers(0); // Reset values
    for (int i = 0; i < WORDS; i++)
      mem_write(8'(i), 32'h9e37_79b9 * (i + 1), 4'hf);
    word_access();
    byte_strobes();
    run_mover(OP_FILL, 8'd0, 8'd40, 16, 32'ha5c3_0f96);
    check_range(39, 18);
    run_mover(OP_COPY, 8'd10, 8'd100, 12, 32'h0);
    check_range(99, 14);
    run_mover(OP_COPY, 8'd60, 8'd61, 8, 32'h0);
    check_range(59, 11);
    run_mover(OP_COPY, 8'd5, 8'd200, 0, 32'h0);
    check_range(199, 3);
    errors_and_backpressure();

    $display("Errors: %0d failed checks, %0d failed assertions", errors,
             dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
mem_pkg.sv
mem_2rw.sv
axil_mem_ctrl.sv
block_mover.sv
mem_subsys_top.sv
mem_subsys_properties.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f verilog.f --top-module tb_mem_subsys -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

# Let assertion errors run on so the testbench reaches its summary
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "FAIL: no final result in sim.log"
  exit 1
fi

echo "PASS"
exit 0
